// ==== src/uart_echo_pkg.sv ====
// shared constants and types for the serial echo unit
// serial timing, line buffer sizing, received byte record
// and the line collector FSM states
package uart_echo_pkg;

	// serial timing, one bit lasts 16 clocks
	localparam int clk_freq_hz = 50_000_000;
	localparam int baud_rate = 3_125_000;
	localparam int clks_per_bit = clk_freq_hz / baud_rate;

	// quiet time that closes a line
	// roughly two and a half character times
	localparam int idle_timeout_clks = 400;

	// line buffer sizing
	localparam int buf_depth = 64;
	// two entries kept free for CR and LF
	localparam int line_max_bytes = buf_depth - 2;
	// lengths and indices, wide enough for buf_depth
	localparam int len_w = 7;

	// one deframed character from the receiver
	typedef struct packed {
		logic [7:0] data;
		// stop bit sampled low
		logic       frame_err;
	} rx_byte_t;

	// line collector FSM
	typedef enum logic [1:0] {
		// waiting for the first byte of a line
		st_idle,
		// storing bytes, idle timer running
		st_collect,
		// replaying the line with CR LF
		st_send
	} echo_state_e;

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/100ps
// 8N1 serial receiver
// pin synchronizer, start bit check at mid-bit, data and stop sampling,
// one byte pulse per frame with a framing error flag
module uart_rx (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    rx,
	output uart_echo_pkg::rx_byte_t rx_byte,
	output logic                    rx_valid
);

	typedef logic [$clog2(uart_echo_pkg::clks_per_bit)-1:0] bit_cnt_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_e;

	rx_state_e  state;
	logic       rx_meta;
	logic       rx_sync;
	bit_cnt_t   clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic       half_bit;
	logic       full_bit;

	// middle of the start bit, then centers of the following bits
	assign half_bit = (clk_cnt == bit_cnt_t'(uart_echo_pkg::clks_per_bit / 2 - 1));
	assign full_bit = (clk_cnt == bit_cnt_t'(uart_echo_pkg::clks_per_bit - 1));

	// two flop synchronizer, idle line is high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= rx_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// line only drops here on a start edge
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start: begin
					if (half_bit) begin
						clk_cnt <= '0;
						// glitch shorter than half a bit
						state   <= rx_sync ? rx_idle : rx_data;
					end else begin
						clk_cnt <= clk_cnt + bit_cnt_t'(1);
					end
				end
				rx_data: begin
					if (full_bit) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end else begin
						clk_cnt <= clk_cnt + bit_cnt_t'(1);
					end
				end
				rx_stop: begin
					// leave at mid stop bit, rest of it is idle high
					if (full_bit) begin
						rx_valid <= 1'b1;
						state    <= rx_idle;
					end else begin
						clk_cnt <= clk_cnt + bit_cnt_t'(1);
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data arrives LSB first
	always_ff @(posedge sys_clk) begin
		if (state == rx_data && full_bit) begin
			shift <= {rx_sync, shift[7:1]};
		end else if (state == rx_stop && full_bit) begin
			rx_byte.data      <= shift;
			rx_byte.frame_err <= !rx_sync;
		end
	end

endmodule

// ==== src/line_echo.sv ====
`timescale 1ns/100ps
// line collector and echo sequencer
// 64 entry line buffer, idle timer, CR LF append and
// replay of the line over a valid/ready byte link
module line_echo (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  uart_echo_pkg::rx_byte_t         rx_byte,
	input  logic                            rx_valid,
	output logic [7:0]                      tx_data,
	output logic                            tx_valid,
	input  logic                            tx_ready,
	output logic [uart_echo_pkg::len_w-1:0] last_len
);

	typedef logic [uart_echo_pkg::len_w-1:0] len_t;
	typedef logic [$clog2(uart_echo_pkg::buf_depth)-1:0] addr_t;
	typedef logic [$clog2(uart_echo_pkg::idle_timeout_clks + 1)-1:0] idle_cnt_t;

	uart_echo_pkg::echo_state_e state;

	logic [7:0] line_buf [uart_echo_pkg::buf_depth];
	len_t       wr_len;
	len_t       rd_idx;
	addr_t      wr_addr;
	addr_t      rd_addr_next;
	idle_cnt_t  idle_cnt;
	logic       rx_accept;
	logic       store_byte;
	logic       timeout;
	logic       tx_fire;
	logic       last_fire;

	// good bytes only, nothing is taken while the line goes out
	assign rx_accept = rx_valid && !rx_byte.frame_err &&
		(state != uart_echo_pkg::st_send);
	// bytes past the limit still keep the line open
	assign store_byte = rx_accept && (wr_len < len_t'(uart_echo_pkg::line_max_bytes));
	assign timeout = (state == uart_echo_pkg::st_collect) && !rx_accept &&
		(idle_cnt == idle_cnt_t'(uart_echo_pkg::idle_timeout_clks));

	assign tx_fire = tx_valid && tx_ready;
	// LF sits one past CR, which sits at wr_len
	assign last_fire = tx_fire && (rd_idx == wr_len + len_t'(1));

	assign wr_addr = addr_t'(wr_len);
	assign rd_addr_next = addr_t'(rd_idx + len_t'(1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_echo_pkg::st_idle;
		end else begin
			case (state)
				uart_echo_pkg::st_idle:
					if (rx_accept)
						state <= uart_echo_pkg::st_collect;
				uart_echo_pkg::st_collect:
					if (timeout)
						state <= uart_echo_pkg::st_send;
				uart_echo_pkg::st_send:
					if (last_fire)
						state <= uart_echo_pkg::st_idle;
				default:
					state <= uart_echo_pkg::st_idle;
			endcase
		end
	end

	// restarts on every accepted byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			idle_cnt <= '0;
		else if (state != uart_echo_pkg::st_collect || rx_accept)
			idle_cnt <= '0;
		else
			idle_cnt <= idle_cnt + idle_cnt_t'(1);
	end

	// payload length of the line being built
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			wr_len <= '0;
		else if (store_byte)
			wr_len <= wr_len + len_t'(1);
		else if (last_fire)
			wr_len <= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (store_byte) begin
			line_buf[wr_addr] <= rx_byte.data;
		end else if (timeout) begin
			// carriage return and line feed behind the payload
			line_buf[wr_addr]               <= 8'h0d;
			line_buf[wr_addr + addr_t'(1)] <= 8'h0a;
		end
	end

	// send side, index of the byte on tx_data
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_valid <= 1'b0;
			rd_idx   <= '0;
			last_len <= '0;
		end else if (timeout) begin
			tx_valid <= 1'b1;
			rd_idx   <= '0;
		end else if (last_fire) begin
			tx_valid <= 1'b0;
			last_len <= wr_len;
		end else if (tx_fire) begin
			rd_idx <= rd_idx + len_t'(1);
		end
	end

	// held until the transmitter takes it
	always_ff @(posedge sys_clk) begin
		if (timeout)
			tx_data <= line_buf[0];
		else if (tx_fire && !last_fire)
			tx_data <= line_buf[rd_addr_next];
	end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps
// 8N1 serial transmitter
// valid/ready byte input, start, 8 data bits LSB first, stop
module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_valid,
	output logic       tx_ready,
	output logic       tx
);

	typedef logic [$clog2(uart_echo_pkg::clks_per_bit)-1:0] bit_cnt_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data_bits,
		tx_stop
	} tx_state_e;

	tx_state_e  state;
	bit_cnt_t   clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic       bit_end;
	logic       tx_fire;

	assign tx_ready = (state == tx_idle);
	assign tx_fire  = tx_valid && tx_ready;
	assign bit_end  = (clk_cnt == bit_cnt_t'(uart_echo_pkg::clks_per_bit - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= tx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else if (state == tx_idle) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			// start bit goes out right after the transfer
			if (tx_fire) begin
				tx    <= 1'b0;
				state <= tx_start;
			end
		end else if (!bit_end) begin
			clk_cnt <= clk_cnt + bit_cnt_t'(1);
		end else begin
			clk_cnt <= '0;
			case (state)
				tx_start: begin
					tx    <= shift[0];
					state <= tx_data_bits;
				end
				tx_data_bits: begin
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7) begin
						tx    <= 1'b1;
						state <= tx_stop;
					end else begin
						tx <= shift[0];
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

	// shift runs one bit ahead of the line
	always_ff @(posedge sys_clk) begin
		if (tx_fire)
			shift <= tx_data;
		else if (bit_end && (state == tx_start || state == tx_data_bits))
			shift <= shift >> 1;
	end

endmodule

// ==== src/uart_echo_top.sv ====
`timescale 1ns/100ps
// serial line echo unit
// receiver, line collector and transmitter in a three stage chain
module uart_echo_top (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  logic                            uart_rx_port,
	output logic                            uart_tx_port,
	output logic [uart_echo_pkg::len_w-1:0] last_len
);

	uart_echo_pkg::rx_byte_t rx_byte;
	logic                    rx_valid;
	logic [7:0]              tx_data;
	logic                    tx_valid;
	logic                    tx_ready;

	uart_rx u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	// no ready back to the receiver, a serial line cannot stall
	line_echo u_line (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.last_len  (last_len)
	);

	uart_tx u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.tx        (uart_tx_port)
	);

endmodule

// ==== verification/uart_echo_tb.sv ====
`timescale 1ns/100ps
// testbench for the serial line echo unit
// clock and reset, serial frame driver, tx line monitor,
// reference echo model, compare process, watchdog and tests
module uart_echo_tb;

	typedef logic [7:0] byte_q_t [$];

	localparam int bit_clks = 16;
	localparam int frame_clks = 10 * bit_clks;
	localparam int single_len = 5;
	localparam int max_pair_len = 16;
	localparam int long_len = 70;
	localparam int bad_line_len = 8;
	localparam int line_count = 5;
	localparam int idle_test_clks = 1000;
	localparam int line_gap_clks = uart_echo_pkg::idle_timeout_clks + 100;
	localparam int tail_quiet_clks = 2 * frame_clks;
	localparam int sent_frames = single_len + 2 * max_pair_len + long_len + bad_line_len;
	localparam int echo_frames = single_len + 2 * max_pair_len + uart_echo_pkg::line_max_bytes +
		(bad_line_len - 1) + 2 * line_count;
	localparam int timeout_clks = (sent_frames + echo_frames) * frame_clks +
		uart_echo_pkg::idle_timeout_clks * line_count + idle_test_clks + line_gap_clks +
		tail_quiet_clks + 2000;

	logic                            sys_clk;
	logic                            sys_rst_n;
	logic                            uart_rx_port;
	logic                            uart_tx_port;
	logic [uart_echo_pkg::len_w-1:0] last_len;

	int         seed = 32'h83f79810;
	int         cycle_cnt = 0;
	int         lines_sent = 0;
	int         lines_checked = 0;
	logic [7:0] rx_q [$];
	logic [7:0] exp_q [$];
	int         len_q [$];
	string      name_q [$];

	uart_echo_top UUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.last_len     (last_len)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %0h actual %0h", test_name, expected, actual);
			stop_with_failure();
		end
	endtask

	// payload capped at the buffer limit and followed by CR LF
	function automatic byte_q_t expected_echo(input byte_q_t sent);
		byte_q_t echo;
		int i;
		for (i = 0; i < sent.size() && i < uart_echo_pkg::line_max_bytes; i++)
			echo.push_back(sent[i]);
		echo.push_back(8'h0d);
		echo.push_back(8'h0a);
		return echo;
	endfunction

	// one 8N1 frame entered and left on a falling edge
	task automatic send_byte(input logic [7:0] data, input logic bad_stop);
		int i;
		uart_rx_port = 1'b0;
		repeat (bit_clks) @(negedge sys_clk);
		for (i = 0; i < 8; i++) begin
			uart_rx_port = data[i];
			repeat (bit_clks) @(negedge sys_clk);
		end
		uart_rx_port = !bad_stop;
		repeat (bit_clks) @(negedge sys_clk);
		uart_rx_port = 1'b1;
		// a quiet bit lets the receiver drop the low stop as a glitch
		if (bad_stop)
			repeat (bit_clks) @(negedge sys_clk);
	endtask

	// sends a random line, queues its echo and waits until it is checked
	task automatic run_line(input string test_name, input int n_bytes, input int bad_pos);
		byte_q_t good;
		byte_q_t echo;
		int i;
		int rnd;
		logic [7:0] data;
		for (i = 0; i < n_bytes; i++) begin
			rnd = $random(seed);
			data = rnd[7:0];
			send_byte(data, i == bad_pos);
			if (i != bad_pos)
				good.push_back(data);
		end
		echo = expected_echo(good);
		foreach (echo[i])
			exp_q.push_back(echo[i]);
		len_q.push_back(echo.size());
		name_q.push_back(test_name);
		lines_sent++;
		while (lines_checked < lines_sent)
			@(negedge sys_clk);
		check_value({test_name, " last_len"}, echo.size() - 2, 32'(last_len));
	endtask

	// decodes uart_tx_port at bit centers on falling edges
	initial begin : tx_monitor
		int i;
		logic [7:0] data;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n && !uart_tx_port) begin
				repeat (bit_clks / 2) @(negedge sys_clk);
				check_value("tx start bit", 0, 32'(uart_tx_port));
				for (i = 0; i < 8; i++) begin
					repeat (bit_clks) @(negedge sys_clk);
					data[i] = uart_tx_port;
				end
				repeat (bit_clks) @(negedge sys_clk);
				check_value("tx stop bit", 1, 32'(uart_tx_port));
				rx_q.push_back(data);
			end
		end
	end

	// compares each finished line against the reference
	initial begin : echo_compare
		int n;
		int i;
		string name;
		logic [7:0] got;
		logic [7:0] want;
		forever begin
			@(negedge sys_clk);
			if (len_q.size() > 0 && rx_q.size() >= len_q[0]) begin
				n = len_q.pop_front();
				name = name_q.pop_front();
				for (i = 0; i < n; i++) begin
					got = rx_q.pop_front();
					want = exp_q.pop_front();
					check_value(name, 32'(want), 32'(got));
				end
				lines_checked++;
			end
		end
	end

	initial begin : watchdog
		forever begin
			@(posedge sys_clk);
			cycle_cnt++;
			if (cycle_cnt >= timeout_clks) begin
				$display("simulation timed out before all echoes arrived");
				stop_with_failure();
			end
		end
	end

	initial begin : stimulus
		int i;
		int rnd;
		int len_a;
		int len_b;
		uart_rx_port = 1'b1;
		sys_rst_n = 1'b0;
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		// quiet line after reset
		for (i = 0; i < idle_test_clks; i++) begin
			@(negedge sys_clk);
			check_value("idle_after_reset tx line", 1, 32'(uart_tx_port));
		end
		check_value("idle_after_reset decoded bytes", 0, 32'(rx_q.size()));
		check_value("idle_after_reset last_len", 0, 32'(last_len));

		run_line("single_line", single_len, -1);

		// two lines of different lengths
		rnd = $random(seed);
		len_a = 1 + (rnd & 15);
		rnd = $random(seed);
		len_b = 1 + (rnd & 15);
		if (len_b == len_a)
			len_b = len_a % 16 + 1;
		run_line("two_lines first", len_a, -1);
		repeat (line_gap_clks) @(negedge sys_clk);
		run_line("two_lines second", len_b, -1);

		run_line("long_line", long_len, -1);
		run_line("bad_stop_line", bad_line_len, 3);

		// no stray frame may follow the last echo
		repeat (tail_quiet_clks) @(negedge sys_clk);
		check_value("end_of_run leftover bytes", 0, 32'(rx_q.size()));
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
src/uart_echo_pkg.sv
src/uart_rx.sv
src/line_echo.sv
src/uart_tx.sv
src/uart_echo_top.sv
verification/uart_echo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the echo unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module uart_echo_tb -o uart_echo_sim

./obj_dir/uart_echo_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
	exit 0
else
	exit 1
fi
